// ==== hdl/eg_consts.svh ====
// envelope generator constants for slot count, widths and the host register map
`ifndef EG_CONSTS_SVH
`define EG_CONSTS_SVH

////////////////////////////////////////
// slot pipeline
`define EG_SLOTS    8        // operator slots served in turn
`define EG_SLOT_W   3        // slot index width
`define EG_PIPE     3        // register stages from issue to eg_out

////////////////////////////////////////
// attenuation and envelope counter
`define EG_LVL_W    10       // 0 is loudest
`define EG_LVL_MAX  10'h3ff  // full attenuation, also the idle level
`define EG_CNT_W    15       // global envelope counter

////////////////////////////////////////
// wishbone side, address = slot*4 + offset
`define EG_ADR_W    8
`define EG_DAT_W    16
`define EG_REG_RATE 2'd0     // ar, d1r
`define EG_REG_REL  2'd1     // d2r, rr, d1l
`define EG_REG_LVL  2'd2     // tl, ks, keycode
`define EG_REG_KEY  8'h20    // key on/off strobe, reads as zero

`endif

// ==== hdl/eg_pkg.sv ====
// envelope generator shared types: envelope phase and operator slot index
`include "eg_consts.svh"

package eg_pkg;

	// envelope phases
	// release doubles as the idle phase after reset
	typedef enum logic [1:0] {
		st_attack  = 2'd0,  // level falls towards 0
		st_decay1  = 2'd1,  // rises to the sustain level
		st_decay2  = 2'd2,  // sustain, slow rise
		st_release = 2'd3   // rises to full attenuation
	} eg_state_t;

	// operator slot index, wraps at EG_SLOTS-1
	typedef logic [`EG_SLOT_W-1:0] slot_t;

endpackage

// ==== hdl/eg_delay.sv ====
// fixed-depth shift register that carries slot data round to its next issue
`timescale 1ns/1ns

module eg_delay #(
	parameter type      payload_t = logic,
	parameter int       depth     = 1,
	parameter payload_t rst_val   = payload_t'(0)  // idle value of every entry
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t din,
	output payload_t dout
);

	payload_t sr [depth];  // sr[0] newest

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < depth; i++)
				sr[i] <= rst_val;
		end else begin
			sr[0] <= din;
			for (int i = 1; i < depth; i++)
				sr[i] <= sr[i-1];
		end
	end

	assign dout = sr[depth-1];  // din from depth cycles ago

endmodule

// ==== hdl/eg_regs.sv ====
// wishbone classic register file with per-slot envelope settings and pending key events
`timescale 1ns/1ns
`include "eg_consts.svh"

module eg_regs (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [`EG_ADR_W-1:0] wb_adr,
	input  logic [`EG_DAT_W-1:0] wb_dat_w,
	input  eg_pkg::slot_t        slot,       // slot being issued
	input  logic                 key_taken,  // stage 1 consumed the flags
	output logic [`EG_DAT_W-1:0] wb_dat_r,
	output logic                 wb_ack,
	output logic [4:0]           ar,
	output logic [4:0]           d1r,
	output logic [4:0]           d2r,
	output logic [3:0]           rr,
	output logic [3:0]           d1l,
	output logic [6:0]           tl,
	output logic [1:0]           ks,
	output logic [4:0]           keycode,
	output logic                 key_on,
	output logic                 key_off
);

	logic [4:0] ar_mem  [`EG_SLOTS];
	logic [4:0] d1r_mem [`EG_SLOTS];
	logic [4:0] d2r_mem [`EG_SLOTS];
	logic [3:0] rr_mem  [`EG_SLOTS];
	logic [3:0] d1l_mem [`EG_SLOTS];
	logic [6:0] tl_mem  [`EG_SLOTS];
	logic [1:0] ks_mem  [`EG_SLOTS];
	logic [4:0] kc_mem  [`EG_SLOTS];
	logic [`EG_SLOTS-1:0] on_pend;    // key on waiting for its slot
	logic [`EG_SLOTS-1:0] off_pend;   // key off waiting for its slot
	logic                 wb_req;     // access seen, ack not yet given
	logic                 adr_cfg;    // address inside the slot window
	eg_pkg::slot_t        adr_slot;
	logic [1:0]           adr_off;
	eg_pkg::slot_t        key_slot;   // target of a key write
	logic [`EG_DAT_W-1:0] rd_mux;

	assign wb_req   = wb_cyc & wb_stb & ~wb_ack;  // ~ack forces the idle cycle
	assign adr_slot = wb_adr[`EG_SLOT_W+1:2];
	assign adr_off  = wb_adr[1:0];
	assign adr_cfg  = (wb_adr[`EG_ADR_W-1:`EG_SLOT_W+2] == '0);
	assign key_slot = wb_dat_w[`EG_SLOT_W-1:0];

	////////////////////////////////////////
	// configuration writes and ack
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			for (int i = 0; i < `EG_SLOTS; i++) begin
				ar_mem[i]  <= '0;
				d1r_mem[i] <= '0;
				d2r_mem[i] <= '0;
				rr_mem[i]  <= '0;
				d1l_mem[i] <= '0;
				tl_mem[i]  <= '0;
				ks_mem[i]  <= '0;
				kc_mem[i]  <= '0;
			end
		end else begin
			wb_ack <= wb_req;  // single cycle, fixed latency
			if (wb_req && wb_we && adr_cfg) begin
				case (adr_off)
					`EG_REG_RATE: begin
						ar_mem[adr_slot]  <= wb_dat_w[4:0];
						d1r_mem[adr_slot] <= wb_dat_w[9:5];
					end
					`EG_REG_REL: begin
						d2r_mem[adr_slot] <= wb_dat_w[4:0];
						rr_mem[adr_slot]  <= wb_dat_w[8:5];
						d1l_mem[adr_slot] <= wb_dat_w[12:9];
					end
					`EG_REG_LVL: begin
						tl_mem[adr_slot] <= wb_dat_w[6:0];
						ks_mem[adr_slot] <= wb_dat_w[8:7];
						kc_mem[adr_slot] <= wb_dat_w[13:9];
					end
					default: ;  // offset 3 is a hole
				endcase
			end
		end
	end

	////////////////////////////////////////
	// pending key events
	always_ff @(posedge clk) begin
		if (rst) begin
			on_pend  <= '0;
			off_pend <= '0;
		end else begin
			if (key_taken) begin
				on_pend[slot]  <= 1'b0;
				off_pend[slot] <= 1'b0;
			end
			// host write comes last so a same-cycle event survives the clear
			if (wb_req && wb_we && (wb_adr == `EG_REG_KEY)) begin
				on_pend[key_slot]  <= wb_dat_w[8];
				off_pend[key_slot] <= ~wb_dat_w[8];  // on and off exclude each other
			end
		end
	end

	// read back, key register and holes give zero
	always_comb begin
		rd_mux = '0;
		if (adr_cfg) begin
			case (adr_off)
				`EG_REG_RATE: rd_mux = {6'd0, d1r_mem[adr_slot], ar_mem[adr_slot]};
				`EG_REG_REL:  rd_mux = {3'd0, d1l_mem[adr_slot], rr_mem[adr_slot],
				                        d2r_mem[adr_slot]};
				`EG_REG_LVL:  rd_mux = {2'd0, kc_mem[adr_slot], ks_mem[adr_slot],
				                        tl_mem[adr_slot]};
				default:      rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wb_req && !wb_we)
			wb_dat_r <= rd_mux;  // valid with ack
	end

	// fields of the slot being issued
	assign ar      = ar_mem[slot];
	assign d1r     = d1r_mem[slot];
	assign d2r     = d2r_mem[slot];
	assign rr      = rr_mem[slot];
	assign d1l     = d1l_mem[slot];
	assign tl      = tl_mem[slot];
	assign ks      = ks_mem[slot];
	assign keycode = kc_mem[slot];
	assign key_on  = on_pend[slot];
	assign key_off = off_pend[slot];

endmodule

// ==== hdl/eg_rate.sv ====
// envelope stage 1 with slot sequencer, key handling, phase changes and scaled rate
`timescale 1ns/1ns
`include "eg_consts.svh"

module eg_rate (
	input  logic                 clk,
	input  logic                 rst,
	input  eg_pkg::eg_state_t    state_in,   // recirculated phase of this slot
	input  logic [4:0]           ar,
	input  logic [4:0]           d1r,
	input  logic [4:0]           d2r,
	input  logic [3:0]           rr,
	input  logic [3:0]           d1l,
	input  logic [6:0]           tl,
	input  logic [1:0]           ks,
	input  logic [4:0]           keycode,
	input  logic                 key_on,
	input  logic                 key_off,
	input  logic [`EG_LVL_W-1:0] level_in,   // recirculated level of this slot
	output eg_pkg::slot_t        slot,       // issue index, drives the register decode
	output logic                 key_taken,
	output eg_pkg::eg_state_t    state_out,
	output logic [5:0]           rate,
	output logic [`EG_LVL_W-1:0] level_out,
	output logic [6:0]           tl_out,
	output logic                 attack_off  // instant attack on this key on
);

	eg_pkg::eg_state_t state_nxt;
	logic [4:0]        d1l_lvl;   // sustain threshold on level[9:5]
	logic [4:0]        base;
	logic [4:0]        ks_add;
	logic [6:0]        rate_sum;  // one spare bit for saturation
	logic [5:0]        rate_nxt;

	////////////////////////////////////////
	// slot sequencer
	always_ff @(posedge clk) begin
		if (rst)
			slot <= '0;
		else if (slot == eg_pkg::slot_t'(`EG_SLOTS - 1))
			slot <= '0;  // wrap
		else
			slot <= slot + 1'b1;
	end

	// flags are used the moment their slot is issued
	assign key_taken = key_on | key_off;

	////////////////////////////////////////
	// phase transitions
	always_comb begin
		d1l_lvl   = (d1l == 4'hf) ? 5'h10 : {1'b0, d1l};  // 15 means 16
		state_nxt = state_in;
		if (key_on) begin
			state_nxt = eg_pkg::st_attack;
		end else if (key_off) begin
			state_nxt = eg_pkg::st_release;
		end else begin
			case (state_in)
				eg_pkg::st_attack: begin
					if (level_in == '0)
						state_nxt = eg_pkg::st_decay1;  // peak reached
				end
				eg_pkg::st_decay1: begin
					if (level_in[`EG_LVL_W-1:5] >= d1l_lvl)
						state_nxt = eg_pkg::st_decay2;  // sustain level reached
				end
				default: state_nxt = state_in;  // decay2 and release hold
			endcase
		end
	end

	////////////////////////////////////////
	// effective rate
	always_comb begin
		case (state_nxt)
			eg_pkg::st_attack: base = ar;
			eg_pkg::st_decay1: base = d1r;
			eg_pkg::st_decay2: base = d2r;
			default:           base = {rr, 1'b1};  // release rate is rr*2+1
		endcase
		ks_add   = keycode >> (2'd3 - ks);  // key scaling
		rate_sum = {1'b0, base, 1'b0} + {2'b00, ks_add};
		if (base == 5'd0)
			rate_nxt = 6'd0;  // frozen
		else if (rate_sum[6])
			rate_nxt = 6'd63;
		else
			rate_nxt = rate_sum[5:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_out  <= eg_pkg::st_release;
			rate       <= '0;
			level_out  <= `EG_LVL_MAX;
			tl_out     <= '0;
			attack_off <= 1'b0;
		end else begin
			state_out  <= state_nxt;  // also feeds the state delay
			rate       <= rate_nxt;
			level_out  <= level_in;
			tl_out     <= tl;
			attack_off <= key_on & (ar == 5'h1f);
		end
	end

endmodule

// ==== hdl/eg_step.sv ====
// envelope stage 2 with round divider, global envelope counter and step decision
`timescale 1ns/1ns
`include "eg_consts.svh"

module eg_step (
	input  logic                 clk,
	input  logic                 rst,
	input  eg_pkg::slot_t        slot,        // issue index, one ahead of this stage
	input  eg_pkg::eg_state_t    state_in,
	input  logic [5:0]           rate,
	input  logic [`EG_LVL_W-1:0] level_in,
	input  logic [6:0]           tl_in,
	input  logic                 attack_off,
	output eg_pkg::slot_t        slot_out,
	output eg_pkg::eg_state_t    state_out,
	output logic [5:0]           rate_out,
	output logic                 step,
	output logic [`EG_LVL_W-1:0] level_out,
	output logic [6:0]           tl_out,
	output logic                 attack_off_out
);

	logic [1:0]           round_div;   // counts full slot rounds, 0..2
	logic [`EG_CNT_W-1:0] eg_cnt;
	logic                 tick_round;  // round that follows a counter tick
	logic [3:0]           grp;
	logic [3:0]           shift;       // counter bits that must be zero
	logic [`EG_CNT_W-1:0] mask;
	logic                 step_now;

	////////////////////////////////////////
	// envelope counter, one tick per three rounds
	always_ff @(posedge clk) begin
		if (rst) begin
			round_div  <= '0;
			eg_cnt     <= '0;
			tick_round <= 1'b0;
		end else if (slot == eg_pkg::slot_t'(`EG_SLOTS - 1)) begin
			if (round_div == 2'd2) begin
				round_div  <= '0;
				eg_cnt     <= eg_cnt + 1'b1;  // ticks on the cycle after the wrap
				tick_round <= 1'b1;
			end else begin
				round_div  <= round_div + 1'b1;
				tick_round <= 1'b0;
			end
		end
	end

	// each slot passes here once while tick_round is high
	always_comb begin
		grp      = (rate[5:2] > 4'd13) ? 4'd13 : rate[5:2];
		shift    = 4'd13 - grp;  // slow rates wait for more counter bits
		mask     = ~({`EG_CNT_W{1'b1}} << shift);
		step_now = tick_round && (rate != 6'd0) && ((eg_cnt & mask) == '0);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_out       <= eg_pkg::slot_t'(`EG_SLOTS - 2);  // keeps the tag stream continuous
			state_out      <= eg_pkg::st_release;
			rate_out       <= '0;
			step           <= 1'b0;
			level_out      <= `EG_LVL_MAX;
			tl_out         <= '0;
			attack_off_out <= 1'b0;
		end else begin
			// slot input already points at the next issue
			if (slot == '0)
				slot_out <= eg_pkg::slot_t'(`EG_SLOTS - 1);
			else
				slot_out <= slot - 1'b1;
			state_out      <= state_in;
			rate_out       <= rate;
			step           <= step_now;
			level_out      <= level_in;
			tl_out         <= tl_in;
			attack_off_out <= attack_off;
		end
	end

endmodule

// ==== hdl/eg_level.sv ====
// envelope stage 3 with level update, total level add and output clamp
`timescale 1ns/1ns
`include "eg_consts.svh"

module eg_level (
	input  logic                 clk,
	input  logic                 rst,
	input  eg_pkg::slot_t        slot,
	input  eg_pkg::eg_state_t    state,
	input  logic [5:0]           rate,
	input  logic                 step,
	input  logic [`EG_LVL_W-1:0] level_in,
	input  logic [6:0]           tl,
	input  logic                 attack_off,
	output logic [`EG_LVL_W-1:0] level_next,  // into the level delay
	output eg_pkg::slot_t        eg_slot,
	output logic [`EG_LVL_W-1:0] eg_out
);

	logic [6:0]           att_dec;  // (level>>4)+1
	logic [`EG_LVL_W-1:0] att_lvl;
	logic [3:0]           dec_inc;
	logic [`EG_LVL_W:0]   dec_sum;  // carry marks overflow
	logic [`EG_LVL_W-1:0] dec_lvl;
	logic [`EG_LVL_W-1:0] lvl_new;
	logic [`EG_LVL_W:0]   out_sum;

	////////////////////////////////////////
	// attack, exponential approach to 0
	always_comb begin
		att_dec = {1'b0, level_in[`EG_LVL_W-1:4]} + 7'd1;
		if (level_in > {3'b000, att_dec})
			att_lvl = level_in - {3'b000, att_dec};
		else
			att_lvl = '0;  // floor at loudest
	end

	////////////////////////////////////////
	// decay and release, linear rise
	always_comb begin
		case (rate[5:2])
			4'd12:   dec_inc = 4'd2;
			4'd13:   dec_inc = 4'd4;
			4'd14,
			4'd15:   dec_inc = 4'd8;
			default: dec_inc = 4'd1;  // every rate below 48
		endcase
		dec_sum = {1'b0, level_in} + {7'd0, dec_inc};
		dec_lvl = dec_sum[`EG_LVL_W] ? `EG_LVL_MAX : dec_sum[`EG_LVL_W-1:0];
	end

	always_comb begin
		if (attack_off)
			lvl_new = '0;  // ar of 31 jumps straight to the peak
		else if (!step)
			lvl_new = level_in;
		else if (state == eg_pkg::st_attack)
			lvl_new = att_lvl;
		else
			lvl_new = dec_lvl;
		out_sum = {1'b0, lvl_new} + {1'b0, tl, 3'b000};  // tl in steps of 8
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			level_next <= `EG_LVL_MAX;
			eg_slot    <= eg_pkg::slot_t'(`EG_SLOTS - 3);  // slot 0 shows up 3 cycles on
			eg_out     <= `EG_LVL_MAX;
		end else begin
			level_next <= lvl_new;
			eg_slot    <= slot;
			eg_out     <= out_sum[`EG_LVL_W] ? `EG_LVL_MAX : out_sum[`EG_LVL_W-1:0];
		end
	end

endmodule

// ==== hdl/eg_top.sv ====
// envelope generator top with register block, three stages and the recirculation delays
`timescale 1ns/1ns
`include "eg_consts.svh"

module eg_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [`EG_ADR_W-1:0] wb_adr,
	input  logic [`EG_DAT_W-1:0] wb_dat_w,
	output logic [`EG_DAT_W-1:0] wb_dat_r,
	output logic                 wb_ack,
	output eg_pkg::slot_t        eg_slot,
	output logic [`EG_LVL_W-1:0] eg_out
);

	// register block to stage 1
	logic [4:0] ar, d1r, d2r, keycode;
	logic [3:0] rr, d1l;
	logic [6:0] tl;
	logic [1:0] ks;
	logic       key_on, key_off, key_taken;
	eg_pkg::slot_t issue_slot;

	// stage 1 to stage 2
	eg_pkg::eg_state_t    s1_state;
	logic [5:0]           s1_rate;
	logic [`EG_LVL_W-1:0] s1_level;
	logic [6:0]           s1_tl;
	logic                 s1_att_off;

	// stage 2 to stage 3
	eg_pkg::slot_t        s2_slot;
	eg_pkg::eg_state_t    s2_state;
	logic [5:0]           s2_rate;
	logic                 s2_step;
	logic [`EG_LVL_W-1:0] s2_level;
	logic [6:0]           s2_tl;
	logic                 s2_att_off;

	// recirculation
	logic [`EG_LVL_W-1:0] level_next, level_back;
	eg_pkg::eg_state_t    state_back;

	eg_regs regs_inst (
		.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.slot (issue_slot), .key_taken, .wb_dat_r, .wb_ack,
		.ar, .d1r, .d2r, .rr, .d1l, .tl, .ks, .keycode, .key_on, .key_off
	);

	eg_rate rate_inst (
		.clk, .rst, .state_in (state_back),
		.ar, .d1r, .d2r, .rr, .d1l, .tl, .ks, .keycode, .key_on, .key_off,
		.level_in (level_back), .slot (issue_slot), .key_taken,
		.state_out (s1_state), .rate (s1_rate), .level_out (s1_level),
		.tl_out (s1_tl), .attack_off (s1_att_off)
	);

	eg_step step_inst (
		.clk, .rst, .slot (issue_slot), .state_in (s1_state), .rate (s1_rate),
		.level_in (s1_level), .tl_in (s1_tl), .attack_off (s1_att_off),
		.slot_out (s2_slot), .state_out (s2_state), .rate_out (s2_rate), .step (s2_step),
		.level_out (s2_level), .tl_out (s2_tl), .attack_off_out (s2_att_off)
	);

	eg_level level_inst (
		.clk, .rst, .slot (s2_slot), .state (s2_state), .rate (s2_rate), .step (s2_step),
		.level_in (s2_level), .tl (s2_tl), .attack_off (s2_att_off),
		.level_next, .eg_slot, .eg_out
	);

	////////////////////////////////////////
	// both loops close exactly EG_SLOTS cycles after issue
	eg_delay #(
		.payload_t (logic [`EG_LVL_W-1:0]),
		.depth     (`EG_SLOTS - `EG_PIPE),  // level leaves at t+3
		.rst_val   (`EG_LVL_MAX)
	) level_dly_inst (
		.clk, .rst, .din (level_next), .dout (level_back)
	);

	eg_delay #(
		.payload_t (eg_pkg::eg_state_t),
		.depth     (`EG_SLOTS - 1),  // phase leaves at t+1
		.rst_val   (eg_pkg::st_release)
	) state_dly_inst (
		.clk, .rst, .din (s1_state), .dout (state_back)
	);

endmodule

// ==== sim/eg_props.sv ====
// bound assertions on the wishbone handshake and the slot sequencer of the envelope generator
`timescale 1ns/1ns
`include "eg_consts.svh"

module eg_props (
	input logic          clk,
	input logic          rst,
	input logic          wb_cyc,
	input logic          wb_stb,
	input logic          wb_ack,
	input eg_pkg::slot_t slot   // stage 1 issue index, as seen by the register decode
);

	// ack only answers an access
	ack_follows_req: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wishbone ack without a preceding cyc and stb");

	// single cycle ack, idle cycle after it
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack)
		else $error("wishbone ack held for two cycles");

	////////////////////////////////////////
	// slot sequencer
	slot_increments: assert property (@(posedge clk) disable iff (rst)
		(slot != eg_pkg::slot_t'(`EG_SLOTS - 1)) |=> (slot == eg_pkg::slot_t'($past(slot) + 1'b1)))
		else $error("slot index skipped a slot");

	slot_wraps: assert property (@(posedge clk) disable iff (rst)
		(slot == eg_pkg::slot_t'(`EG_SLOTS - 1)) |=> (slot == '0))
		else $error("slot index did not wrap to 0");

endmodule

// the register block sees the issue slot, so one bind covers both blocks
bind eg_regs eg_props props_inst (.clk, .rst, .wb_cyc, .wb_stb, .wb_ack, .slot);

// ==== sim/eg_tb.sv ====
// directed envelope generator testbench with wishbone host setup and per-slot sampling
`timescale 1ns/1ns
`include "eg_consts.svh"

module eg_tb;

	localparam int tick_cycles = 3 * `EG_SLOTS;  // clocks per envelope counter tick
	localparam int rpt         = 3;              // slot rounds per tick
	// test budgets in counter ticks
	localparam int b_regs    = 10;
	localparam int b_inst    = 20;
	localparam int b_attack  = 200;    // ~80 attack steps at one per tick
	localparam int b_decay   = 2400;   // 256 steps at one per 8 ticks
	localparam int b_release = 150;    // 767 levels in steps of 8
	localparam int b_restart = 5;
	localparam int b_indep   = 700;    // 64 steps at one per 8 ticks
	localparam int total_ticks = b_regs + b_inst + b_attack + b_decay + b_release
		+ b_restart + b_indep + 100;  // plus hold time
	localparam int watchdog_ns = total_ticks * tick_cycles * 10 + 20000;
	localparam int dir_any  = 0;
	localparam int dir_down = 1;  // output must not rise
	localparam int dir_up   = 2;  // output must not fall

	logic                 clk;
	logic                 rst;
	logic                 wb_cyc, wb_stb, wb_we, wb_ack;
	logic [`EG_ADR_W-1:0] wb_adr;
	logic [`EG_DAT_W-1:0] wb_dat_w, wb_dat_r;
	eg_pkg::slot_t        eg_slot;
	logic [`EG_LVL_W-1:0] eg_out;
	int                   errors;

	eg_top eg_top_inst (
		.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
		.wb_dat_r, .wb_ack, .eg_slot, .eg_out
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;  // 10 ns

	////////////////////////////////////////
	// helpers
	task automatic check(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
			errors = errors + 1;
		end
	endtask

	task automatic wb_access(input logic we, input logic [7:0] adr, input logic [15:0] dat,
		output logic [15:0] rdat);
		int guard;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
		end while (!wb_ack && guard < 16);
		if (!wb_ack) begin
			$display("no wishbone ack for access to address %0h", adr);
			errors = errors + 1;
		end
		rdat = wb_dat_r;  // valid with ack
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [15:0] dat);
		logic [15:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [15:0] dat);
		wb_access(1'b0, adr, 16'h0000, dat);
	endtask

	function automatic logic [7:0] reg_adr(input eg_pkg::slot_t s, input logic [1:0] off);
		return {3'b000, s, off};  // slot*4 + offset
	endfunction

	// field widths of the rate, rel and lvl registers
	function automatic logic [15:0] field_mask(input int k);
		case (k)
			0:       return 16'h03ff;
			1:       return 16'h1fff;
			default: return 16'h3fff;
		endcase
	endfunction

	// level plus tl*8 clamped at full attenuation
	function automatic logic [15:0] exp_out(input logic [15:0] lvl, input logic [6:0] tl);
		logic [15:0] sum;
		sum = lvl + {6'd0, tl, 3'b000};
		return (sum > 16'h03ff) ? 16'h03ff : sum;
	endfunction

	task automatic cfg_slot(input eg_pkg::slot_t s, input logic [4:0] ar, input logic [4:0] d1r,
		input logic [4:0] d2r, input logic [3:0] rr, input logic [3:0] d1l,
		input logic [6:0] tl, input logic [1:0] ks, input logic [4:0] kc);
		wb_write(reg_adr(s, `EG_REG_RATE), {6'd0, d1r, ar});
		wb_write(reg_adr(s, `EG_REG_REL), {3'd0, d1l, rr, d2r});
		wb_write(reg_adr(s, `EG_REG_LVL), {2'd0, kc, ks, tl});
	endtask

	task automatic key_event(input eg_pkg::slot_t s, input logic on);
		wb_write(`EG_REG_KEY, {7'd0, on, 5'd0, s});
	endtask

	// waits at least one clock for the next output of slot s
	task automatic sample_slot(input eg_pkg::slot_t s, output logic [15:0] v);
		int guard;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
		end while (eg_slot != s && guard < 2 * `EG_SLOTS);
		if (eg_slot != s) begin
			$display("eg_slot never showed slot %0d", s);
			errors = errors + 1;
		end
		v = {6'd0, eg_out};
	endtask

	// poll one slot each round until target, then hold there
	task automatic settle(input string name, input eg_pkg::slot_t s, input logic [15:0] target,
		input int dir, input int budget, input int hold);
		logic [15:0] v;
		logic [15:0] prev;
		int n;
		int i;
		sample_slot(s, v);
		prev = v;
		n = 0;
		while (v != target && n < budget) begin
			sample_slot(s, v);
			if (dir == dir_down && v > prev) begin
				$display("%s: slot %0d output rose from %0h to %0h", name, s, prev, v);
				errors = errors + 1;
			end
			if (dir == dir_up && v < prev) begin
				$display("%s: slot %0d output fell from %0h to %0h", name, s, prev, v);
				errors = errors + 1;
			end
			prev = v;
			n++;
		end
		check(name, target, v);  // misses the target on budget overrun
		for (i = 0; i < hold; i++) begin
			sample_slot(s, v);
			check(name, target, v);
		end
	endtask

	////////////////////////////////////////
	// tests
	task automatic test_reset_regs();
		logic [15:0] wr [3][`EG_SLOTS];
		logic [15:0] v;
		logic [31:0] rnd;
		int s;
		int k;
		// slot 0 reaches eg_slot three clocks after reset, then one slot per clock
		repeat (3) @(posedge clk);
		for (s = 0; s < 2 * `EG_SLOTS; s++) begin
			@(negedge clk);
			check("slot_order", 16'(s % `EG_SLOTS), {13'd0, eg_slot});
		end
		for (s = 0; s < `EG_SLOTS; s++) begin
			sample_slot(eg_pkg::slot_t'(s), v);
			check("reset_level", 16'h03ff, v);
		end
		for (s = 0; s < `EG_SLOTS; s++) begin
			for (k = 0; k < 3; k++) begin
				rnd = $urandom();
				wr[k][s] = rnd[15:0];  // upper bits beyond the fields too
				wb_write(reg_adr(eg_pkg::slot_t'(s), 2'(k)), rnd[15:0]);
			end
		end
		for (s = 0; s < `EG_SLOTS; s++) begin
			for (k = 0; k < 3; k++) begin
				wb_read(reg_adr(eg_pkg::slot_t'(s), 2'(k)), v);
				check("reg_readback", wr[k][s] & field_mask(k), v);
			end
		end
		wb_read(`EG_REG_KEY, v);
		check("key_reads_zero", 16'h0000, v);
	endtask

	task automatic test_instant_attack();
		logic [31:0] rnd;
		logic [6:0]  tl;
		logic [15:0] v;
		rnd = $urandom();
		tl  = rnd[6:0];
		cfg_slot(3'd1, 5'd31, 5'd0, 5'd0, 4'd0, 4'd0, tl, 2'd0, 5'd0);
		key_event(3'd1, 1'b1);
		settle("instant_attack", 3'd1, exp_out(16'd0, tl), dir_any, b_inst * rpt, 6);
		wb_write(reg_adr(3'd1, `EG_REG_LVL), {2'd0, 5'd0, 2'd0, 7'd127});  // largest tl
		settle("instant_attack_tl127", 3'd1, exp_out(16'd0, 7'd127), dir_any, 6, 3);
		sample_slot(3'd0, v);
		check("idle_slot0", 16'h03ff, v);
		sample_slot(3'd7, v);
		check("idle_slot7", 16'h03ff, v);
	endtask

	task automatic test_normal_attack();
		logic [31:0] rnd;
		logic [6:0]  tl;
		rnd = $urandom();
		tl  = rnd[6:0];
		cfg_slot(3'd2, 5'd28, 5'd0, 5'd0, 4'd0, 4'd0, tl, 2'd0, 5'd0);  // rate 56
		key_event(3'd2, 1'b1);
		settle("normal_attack", 3'd2, exp_out(16'd0, tl), dir_down, b_attack * rpt, 6);
	endtask

	task automatic test_decay_sustain();
		cfg_slot(3'd3, 5'd31, 5'd20, 5'd0, 4'd15, 4'd8, 7'd0, 2'd0, 5'd0);  // rr for release
		key_event(3'd3, 1'b1);
		settle("decay_peak", 3'd3, 16'h0000, dir_any, 2 * rpt, 0);
		// sustain at d1l*32, then decay2 frozen
		settle("decay_sustain", 3'd3, 16'd256, dir_up, b_decay * rpt, 20 * rpt);
	endtask

	task automatic test_release();
		key_event(3'd3, 1'b0);
		settle("release", 3'd3, 16'h03ff, dir_up, b_release * rpt, 6);
		key_event(3'd3, 1'b1);
		settle("attack_restart", 3'd3, 16'h0000, dir_any, b_restart * rpt, 0);
	endtask

	task automatic test_independence();
		logic [31:0] rnd;
		logic [6:0]  tl;
		logic [15:0] v;
		rnd = $urandom();
		tl  = rnd[6:0];
		cfg_slot(3'd5, 5'd31, 5'd0, 5'd0, 4'd0, 4'd0, tl, 2'd0, 5'd0);
		cfg_slot(3'd6, 5'd31, 5'd20, 5'd0, 4'd0, 4'd2, 7'd0, 2'd0, 5'd0);  // sustain at 64
		key_event(3'd6, 1'b1);
		repeat (5) @(posedge clk);  // staggered key timing
		key_event(3'd5, 1'b1);
		settle("indep_slot5", 3'd5, exp_out(16'd0, tl), dir_any, b_inst * rpt, 3);
		settle("indep_slot6", 3'd6, 16'd64, dir_up, b_indep * rpt, 20 * rpt);
		sample_slot(3'd5, v);
		check("indep_slot5_hold", exp_out(16'd0, tl), v);
	endtask

	////////////////////////////////////////
	// run control
	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		errors   = 0;
		void'($urandom(32'he71c906c));
		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		test_reset_regs();
		test_instant_attack();
		test_normal_attack();
		test_decay_sustain();
		test_release();
		test_independence();
		$display("tests done, %0d errors", errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/eg_pkg.sv
hdl/eg_delay.sv
hdl/eg_regs.sv
hdl/eg_rate.sv
hdl/eg_step.sv
hdl/eg_level.sv
hdl/eg_top.sv
sim/eg_props.sv
sim/eg_tb.sv

// ==== run.sh ====
#!/bin/bash
# build the envelope generator testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -f project.f --top-module eg_tb -Mdir obj_dir \
	&& ./obj_dir/Veg_tb > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
